//--- common/mmu_pkg.sv
package mmu_pkg;

    // widths
    localparam int XLEN       = 32;
    localparam int VPPN_W     = 19;
    localparam int PPN_W      = 20;
    localparam int ASID_W     = 10;
    localparam int SEG_W      = 3;
    localparam int PAGE_OFS_W = 12;

    // tlb geometry
    localparam int TLB_NUM   = 16;
    localparam int TLB_IDX_W = 4;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [XLEN-1:0]      vaddr_t;
    typedef logic [XLEN-1:0]      paddr_t;
    typedef logic [XLEN/8-1:0]    wstrb_t;
    typedef logic [VPPN_W-1:0]    vppn_t;
    typedef logic [PPN_W-1:0]     ppn_t;
    typedef logic [ASID_W-1:0]    asid_t;
    typedef logic [TLB_IDX_W-1:0] tlb_idx_t;
    typedef logic [SEG_W-1:0]     seg_t;

    // one entry covers an even/odd pair of 4 KB pages
    typedef struct packed {
        logic  e;
        vppn_t vppn;
        asid_t asid;
        logic  g;
        ppn_t  ppn0;
        logic  v0;
        ppn_t  ppn1;
        logic  v1;
    } tlb_entry_t;

endpackage

//--- tlb/tlb.sv
`timescale 1ns/1ps

module tlb (
    input  logic               clk,
    input  logic               rst,
    input  mmu_pkg::asid_t     asid,
    // search port 0 for fetch
    input  mmu_pkg::vppn_t     s0_vppn,
    input  logic               s0_va_bit12,
    output logic               s0_found,
    output mmu_pkg::ppn_t      s0_ppn,
    output logic               s0_v,
    // search port 1 for load/store
    input  mmu_pkg::vppn_t     s1_vppn,
    input  logic               s1_va_bit12,
    output logic               s1_found,
    output mmu_pkg::ppn_t      s1_ppn,
    output logic               s1_v,
    // write port
    input  logic               we,
    input  mmu_pkg::tlb_idx_t  w_index,
    input  logic               w_e,
    input  mmu_pkg::vppn_t     w_vppn,
    input  mmu_pkg::asid_t     w_asid,
    input  logic               w_g,
    input  mmu_pkg::ppn_t      w_ppn0,
    input  logic               w_v0,
    input  mmu_pkg::ppn_t      w_ppn1,
    input  logic               w_v1
);

    import mmu_pkg::*;

    tlb_entry_t tlb_mem [TLB_NUM];

    function automatic logic entry_hit(tlb_entry_t ent, vppn_t vppn, asid_t cur_asid);
        return ent.e && (ent.vppn == vppn) && (ent.g || (ent.asid == cur_asid));
    endfunction

    // reset invalidates every entry
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TLB_NUM; i++) begin
                tlb_mem[i].e <= 1'b0;
            end
        end else if (we) begin
            tlb_mem[w_index] <= '{
                e:    w_e,
                vppn: w_vppn,
                asid: w_asid,
                g:    w_g,
                ppn0: w_ppn0,
                v0:   w_v0,
                ppn1: w_ppn1,
                v1:   w_v1
            };
        end
    end

    // bit 12 picks the odd page of the pair
    always_comb begin
        s0_found = 1'b0;
        s0_ppn   = '0;
        s0_v     = 1'b0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (entry_hit(tlb_mem[i], s0_vppn, asid)) begin
                s0_found = 1'b1;
                s0_ppn   = s0_va_bit12 ? tlb_mem[i].ppn1 : tlb_mem[i].ppn0;
                s0_v     = s0_va_bit12 ? tlb_mem[i].v1 : tlb_mem[i].v0;
            end
        end
    end

    always_comb begin
        s1_found = 1'b0;
        s1_ppn   = '0;
        s1_v     = 1'b0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (entry_hit(tlb_mem[i], s1_vppn, asid)) begin
                s1_found = 1'b1;
                s1_ppn   = s1_va_bit12 ? tlb_mem[i].ppn1 : tlb_mem[i].ppn0;
                s1_v     = s1_va_bit12 ? tlb_mem[i].v1 : tlb_mem[i].v0;
            end
        end
    end

endmodule

//--- design/access_port.sv
`timescale 1ns/1ps

module access_port (
    input  logic            clk,
    input  logic            rst,
    // client side
    input  logic            valid,
    input  logic            wr,
    input  mmu_pkg::vaddr_t vaddr,
    input  mmu_pkg::wstrb_t wstrb,
    input  mmu_pkg::word_t  wdata,
    output logic            busy,
    output logic            done,
    output logic            fault,
    output mmu_pkg::word_t  rdata,
    // translation config
    input  logic            direct_addr,
    input  logic            dmw0_en,
    input  mmu_pkg::seg_t   dmw0_vseg,
    input  mmu_pkg::seg_t   dmw0_pseg,
    input  logic            dmw1_en,
    input  mmu_pkg::seg_t   dmw1_vseg,
    input  mmu_pkg::seg_t   dmw1_pseg,
    // tlb search port
    output mmu_pkg::vppn_t  tlb_vppn,
    output logic            tlb_va_bit12,
    input  logic            tlb_found,
    input  logic            tlb_v,
    input  mmu_pkg::ppn_t   tlb_ppn,
    // request side toward the arbiter
    output logic            req,
    output logic            req_wr,
    output mmu_pkg::paddr_t req_addr,
    output mmu_pkg::wstrb_t req_wstrb,
    output mmu_pkg::word_t  req_wdata,
    input  logic            addr_ok,
    input  logic            data_ok,
    input  mmu_pkg::word_t  rdata_in
);

    import mmu_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_t;

    state_t state;
    vaddr_t vaddr_q;
    logic   wr_q;
    wstrb_t wstrb_q;
    word_t  wdata_q;
    word_t  rdata_q;
    logic   done_q;
    paddr_t paddr;
    logic   xlate_fault;
    seg_t   va_seg;

    // access captured on the valid strobe
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && valid) begin
            vaddr_q <= vaddr;
            wr_q    <= wr;
            wstrb_q <= wstrb;
            wdata_q <= wdata;
        end
        if (state == ST_WAIT && data_ok) begin
            rdata_q <= rdata_in;
        end
    end

    assign va_seg       = vaddr_q[XLEN-1 -: SEG_W];
    assign tlb_vppn     = vaddr_q[XLEN-1 -: VPPN_W];
    assign tlb_va_bit12 = vaddr_q[PAGE_OFS_W];

    // direct, then dmw0, then dmw1, then tlb
    always_comb begin
        xlate_fault = 1'b0;
        if (direct_addr) begin
            paddr = vaddr_q;
        end else if (dmw0_en && dmw0_vseg == va_seg) begin
            paddr = {dmw0_pseg, vaddr_q[XLEN-SEG_W-1:0]};
        end else if (dmw1_en && dmw1_vseg == va_seg) begin
            paddr = {dmw1_pseg, vaddr_q[XLEN-SEG_W-1:0]};
        end else begin
            paddr       = {tlb_ppn, vaddr_q[PAGE_OFS_W-1:0]};
            xlate_fault = !(tlb_found && tlb_v);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            done_q <= 1'b0;
        end else begin
            done_q <= (state == ST_WAIT) && data_ok;
            case (state)
                ST_IDLE: if (valid) state <= ST_REQ;
                ST_REQ: begin
                    if (xlate_fault) begin
                        state <= ST_IDLE;
                    end else if (addr_ok) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: if (data_ok) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // fault only in the first request cycle, before anything reaches the bus
    assign fault     = (state == ST_REQ) && xlate_fault;
    assign req       = (state == ST_REQ) && !xlate_fault;
    assign req_wr    = wr_q;
    assign req_addr  = paddr;
    assign req_wstrb = wstrb_q;
    assign req_wdata = wdata_q;

    assign busy  = (state != ST_IDLE) || done_q;
    assign done  = done_q;
    assign rdata = rdata_q;

endmodule

//--- design/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
    input  logic            clk,
    input  logic            rst,
    // fetch port, read only
    input  logic            f_req,
    input  mmu_pkg::paddr_t f_addr,
    output logic            f_addr_ok,
    output logic            f_data_ok,
    // data port
    input  logic            d_req,
    input  logic            d_wr,
    input  mmu_pkg::paddr_t d_addr,
    input  mmu_pkg::wstrb_t d_wstrb,
    input  mmu_pkg::word_t  d_wdata,
    output logic            d_addr_ok,
    output logic            d_data_ok,
    // shared sram bus
    output logic            sram_req,
    output logic            sram_wr,
    output mmu_pkg::paddr_t sram_addr,
    output mmu_pkg::wstrb_t sram_wstrb,
    output mmu_pkg::word_t  sram_wdata,
    input  logic            sram_addr_ok,
    input  logic            sram_data_ok
);

    logic outstanding;
    logic pending;
    // owner high means the data port
    logic owner;
    logic sel_d;

    // a request already on the bus keeps its grant until addr_ok
    assign sel_d    = pending ? owner : d_req;
    assign sram_req = !outstanding && (pending || d_req || f_req);

    assign sram_wr    = sel_d && d_wr;
    assign sram_addr  = sel_d ? d_addr : f_addr;
    assign sram_wstrb = sel_d ? d_wstrb : '0;
    assign sram_wdata = d_wdata;

    assign d_addr_ok = sram_req && sram_addr_ok && sel_d;
    assign f_addr_ok = sram_req && sram_addr_ok && !sel_d;
    assign d_data_ok = outstanding && sram_data_ok && owner;
    assign f_data_ok = outstanding && sram_data_ok && !owner;

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
            pending     <= 1'b0;
            owner       <= 1'b0;
        end else begin
            if (outstanding && sram_data_ok) begin
                outstanding <= 1'b0;
            end
            if (sram_req) begin
                owner <= sel_d;
                if (sram_addr_ok) begin
                    pending     <= 1'b0;
                    outstanding <= 1'b1;
                end else begin
                    pending <= 1'b1;
                end
            end
        end
    end

endmodule

//--- design/core_mem_top.sv
`timescale 1ns/1ps

module core_mem_top (
    input  logic              clk,
    input  logic              rst,
    // translation config
    input  logic              direct_addr,
    input  logic              dmw0_en,
    input  mmu_pkg::seg_t     dmw0_vseg,
    input  mmu_pkg::seg_t     dmw0_pseg,
    input  logic              dmw1_en,
    input  mmu_pkg::seg_t     dmw1_vseg,
    input  mmu_pkg::seg_t     dmw1_pseg,
    input  mmu_pkg::asid_t    asid,
    // tlb write port
    input  logic              tlb_we,
    input  mmu_pkg::tlb_idx_t w_index,
    input  logic              w_e,
    input  mmu_pkg::vppn_t    w_vppn,
    input  mmu_pkg::asid_t    w_asid,
    input  logic              w_g,
    input  mmu_pkg::ppn_t     w_ppn0,
    input  logic              w_v0,
    input  mmu_pkg::ppn_t     w_ppn1,
    input  logic              w_v1,
    // fetch client
    input  logic              fetch_valid,
    input  mmu_pkg::vaddr_t   fetch_vaddr,
    output logic              fetch_busy,
    output logic              fetch_done,
    output logic              fetch_fault,
    output mmu_pkg::word_t    fetch_rdata,
    // data client
    input  logic              data_valid,
    input  logic              data_wr,
    input  mmu_pkg::wstrb_t   data_wstrb,
    input  mmu_pkg::vaddr_t   data_vaddr,
    input  mmu_pkg::word_t    data_wdata,
    output logic              data_busy,
    output logic              data_done,
    output logic              data_fault,
    output mmu_pkg::word_t    data_rdata,
    // shared sram bus
    output logic              sram_req,
    output logic              sram_wr,
    output mmu_pkg::paddr_t   sram_addr,
    output mmu_pkg::wstrb_t   sram_wstrb,
    output mmu_pkg::word_t    sram_wdata,
    input  logic              sram_addr_ok,
    input  logic              sram_data_ok,
    input  mmu_pkg::word_t    sram_rdata
);

    import mmu_pkg::*;

    // tlb search, port 0 fetch and port 1 data
    vppn_t  s0_vppn;
    logic   s0_va_bit12;
    logic   s0_found;
    ppn_t   s0_ppn;
    logic   s0_v;
    vppn_t  s1_vppn;
    logic   s1_va_bit12;
    logic   s1_found;
    ppn_t   s1_ppn;
    logic   s1_v;

    logic   f_req;
    paddr_t f_addr;
    logic   f_addr_ok;
    logic   f_data_ok;
    logic   d_req;
    logic   d_wr;
    paddr_t d_addr;
    wstrb_t d_wstrb;
    word_t  d_wdata;
    logic   d_addr_ok;
    logic   d_data_ok;

    tlb i_tlb (
        .clk        (clk),
        .rst        (rst),
        .asid       (asid),
        .s0_vppn    (s0_vppn),
        .s0_va_bit12(s0_va_bit12),
        .s0_found   (s0_found),
        .s0_ppn     (s0_ppn),
        .s0_v       (s0_v),
        .s1_vppn    (s1_vppn),
        .s1_va_bit12(s1_va_bit12),
        .s1_found   (s1_found),
        .s1_ppn     (s1_ppn),
        .s1_v       (s1_v),
        .we         (tlb_we),
        .w_index    (w_index),
        .w_e        (w_e),
        .w_vppn     (w_vppn),
        .w_asid     (w_asid),
        .w_g        (w_g),
        .w_ppn0     (w_ppn0),
        .w_v0       (w_v0),
        .w_ppn1     (w_ppn1),
        .w_v1       (w_v1)
    );

    // fetch never writes
    access_port i_fetch_port (
        .clk         (clk),
        .rst         (rst),
        .valid       (fetch_valid),
        .wr          (1'b0),
        .vaddr       (fetch_vaddr),
        .wstrb       ('0),
        .wdata       ('0),
        .busy        (fetch_busy),
        .done        (fetch_done),
        .fault       (fetch_fault),
        .rdata       (fetch_rdata),
        .direct_addr (direct_addr),
        .dmw0_en     (dmw0_en),
        .dmw0_vseg   (dmw0_vseg),
        .dmw0_pseg   (dmw0_pseg),
        .dmw1_en     (dmw1_en),
        .dmw1_vseg   (dmw1_vseg),
        .dmw1_pseg   (dmw1_pseg),
        .tlb_vppn    (s0_vppn),
        .tlb_va_bit12(s0_va_bit12),
        .tlb_found   (s0_found),
        .tlb_v       (s0_v),
        .tlb_ppn     (s0_ppn),
        .req         (f_req),
        .req_wr      (),
        .req_addr    (f_addr),
        .req_wstrb   (),
        .req_wdata   (),
        .addr_ok     (f_addr_ok),
        .data_ok     (f_data_ok),
        .rdata_in    (sram_rdata)
    );

    access_port i_data_port (
        .clk         (clk),
        .rst         (rst),
        .valid       (data_valid),
        .wr          (data_wr),
        .vaddr       (data_vaddr),
        .wstrb       (data_wstrb),
        .wdata       (data_wdata),
        .busy        (data_busy),
        .done        (data_done),
        .fault       (data_fault),
        .rdata       (data_rdata),
        .direct_addr (direct_addr),
        .dmw0_en     (dmw0_en),
        .dmw0_vseg   (dmw0_vseg),
        .dmw0_pseg   (dmw0_pseg),
        .dmw1_en     (dmw1_en),
        .dmw1_vseg   (dmw1_vseg),
        .dmw1_pseg   (dmw1_pseg),
        .tlb_vppn    (s1_vppn),
        .tlb_va_bit12(s1_va_bit12),
        .tlb_found   (s1_found),
        .tlb_v       (s1_v),
        .tlb_ppn     (s1_ppn),
        .req         (d_req),
        .req_wr      (d_wr),
        .req_addr    (d_addr),
        .req_wstrb   (d_wstrb),
        .req_wdata   (d_wdata),
        .addr_ok     (d_addr_ok),
        .data_ok     (d_data_ok),
        .rdata_in    (sram_rdata)
    );

    bus_arbiter i_bus_arbiter (
        .clk         (clk),
        .rst         (rst),
        .f_req       (f_req),
        .f_addr      (f_addr),
        .f_addr_ok   (f_addr_ok),
        .f_data_ok   (f_data_ok),
        .d_req       (d_req),
        .d_wr        (d_wr),
        .d_addr      (d_addr),
        .d_wstrb     (d_wstrb),
        .d_wdata     (d_wdata),
        .d_addr_ok   (d_addr_ok),
        .d_data_ok   (d_data_ok),
        .sram_req    (sram_req),
        .sram_wr     (sram_wr),
        .sram_addr   (sram_addr),
        .sram_wstrb  (sram_wstrb),
        .sram_wdata  (sram_wdata),
        .sram_addr_ok(sram_addr_ok),
        .sram_data_ok(sram_data_ok)
    );

endmodule

//--- sim/tb_core_mem.sv
`timescale 1ns/1ps

module tb_core_mem;

    import mmu_pkg::*;

    localparam int TIMEOUT  = 50;
    localparam int NUM_ROWS = 19;
    localparam int CL_FETCH = 0;
    localparam int CL_DATA  = 1;
    localparam int CL_BOTH  = 2;

    typedef struct packed {
        logic  direct;
        logic  dmw0_en;
        seg_t  dmw0_vseg;
        seg_t  dmw0_pseg;
        logic  dmw1_en;
        seg_t  dmw1_vseg;
        seg_t  dmw1_pseg;
        asid_t asid;
    } cfg_t;

    // tlb_sel of -1 means no tlb write before the access
    typedef struct {
        int     cfg_sel;
        int     tlb_sel;
        int     client;
        logic   wr;
        vaddr_t vaddr;
        word_t  wdata;
        wstrb_t wstrb;
    } row_t;

    logic     clk;
    logic     rst;
    logic     direct_addr, dmw0_en, dmw1_en;
    seg_t     dmw0_vseg, dmw0_pseg, dmw1_vseg, dmw1_pseg;
    asid_t    asid;
    logic     tlb_we, w_e, w_g, w_v0, w_v1;
    tlb_idx_t w_index;
    vppn_t    w_vppn;
    asid_t    w_asid;
    ppn_t     w_ppn0, w_ppn1;
    logic     fetch_valid, fetch_busy, fetch_done, fetch_fault;
    vaddr_t   fetch_vaddr;
    word_t    fetch_rdata;
    logic     data_valid, data_wr, data_busy, data_done, data_fault;
    wstrb_t   data_wstrb;
    vaddr_t   data_vaddr;
    word_t    data_wdata, data_rdata;
    logic     sram_req, sram_wr, sram_addr_ok, sram_data_ok;
    paddr_t   sram_addr;
    wstrb_t   sram_wstrb;
    word_t    sram_wdata, sram_rdata;

    cfg_t       cfgs [5];
    tlb_entry_t tlb_writes [2];
    tlb_idx_t   tlb_write_idx [2];
    row_t       rows [NUM_ROWS];
    tlb_entry_t tlb_model [TLB_NUM];
    word_t      mem [256];
    word_t      shadow [256];
    paddr_t     xfer_log [64];
    int         xfer_count;
    int         req_cycles;
    int         mismatches;
    int         failures;

    core_mem_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t fill_word(input int idx);
        return {idx[7:0] ^ 8'h5a, ~idx[7:0], idx[7:0], idx[7:0] + 8'hc3};
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t nw, input wstrb_t strb);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = nw[8*b +: 8];
        end
        return res;
    endfunction

    // direct, dmw0, dmw1, then tlb lookup on the reference entries
    function automatic void ref_translate(input cfg_t c, input vaddr_t va,
                                          output paddr_t pa, output logic flt);
        logic       hit;
        tlb_entry_t ent;
        hit = 1'b0;
        ent = '0;
        flt = 1'b0;
        pa  = va;
        if (c.direct) begin
            pa = va;
        end else if (c.dmw0_en && c.dmw0_vseg == va[31:29]) begin
            pa = {c.dmw0_pseg, va[28:0]};
        end else if (c.dmw1_en && c.dmw1_vseg == va[31:29]) begin
            pa = {c.dmw1_pseg, va[28:0]};
        end else begin
            for (int i = 0; i < TLB_NUM; i++) begin
                if (tlb_model[i].e && tlb_model[i].vppn == va[31:13] &&
                    (tlb_model[i].g || tlb_model[i].asid == c.asid)) begin
                    hit = 1'b1;
                    ent = tlb_model[i];
                end
            end
            if (!hit || (va[12] ? !ent.v1 : !ent.v0)) begin
                flt = 1'b1;
            end else begin
                pa = {(va[12] ? ent.ppn1 : ent.ppn0), va[11:0]};
            end
        end
    endfunction

    task automatic check_paddr(input string what, input paddr_t got, input paddr_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic load_table();
        // direct, dmw split, both windows on one segment, tlb asid 5, tlb asid 9
        cfgs[0] = '{1'b1, 1'b0, 3'h0, 3'h0, 1'b0, 3'h0, 3'h0, 10'h005};
        cfgs[1] = '{1'b0, 1'b1, 3'h4, 3'h0, 1'b1, 3'h5, 3'h1, 10'h005};
        cfgs[2] = '{1'b0, 1'b1, 3'h6, 3'h2, 1'b1, 3'h6, 3'h3, 10'h005};
        cfgs[3] = '{1'b0, 1'b0, 3'h0, 3'h0, 1'b0, 3'h0, 3'h0, 10'h005};
        cfgs[4] = '{1'b0, 1'b0, 3'h0, 3'h0, 1'b0, 3'h0, 3'h0, 10'h009};
        tlb_write_idx[0] = 4'd1;
        tlb_writes[0] = '{1'b1, 19'h00012, 10'h005, 1'b0, 20'h00100, 1'b1, 20'h00201, 1'b1};
        // global entry with the odd page not valid
        tlb_write_idx[1] = 4'd2;
        tlb_writes[1] = '{1'b1, 19'h00030, 10'h007, 1'b1, 20'h00333, 1'b1, 20'h00444, 1'b0};
        rows[0]  = '{0, -1, CL_DATA,  1'b0, 32'h0000_0010, 32'h0, 4'h0};
        rows[1]  = '{0, -1, CL_FETCH, 1'b0, 32'h0000_0104, 32'h0, 4'h0};
        rows[2]  = '{0, -1, CL_DATA,  1'b1, 32'h0000_0020, 32'h1122_3344, 4'b0101};
        rows[3]  = '{0, -1, CL_DATA,  1'b0, 32'h0000_0020, 32'h0, 4'h0};
        rows[4]  = '{1, -1, CL_DATA,  1'b0, 32'h8000_0234, 32'h0, 4'h0};
        rows[5]  = '{1, -1, CL_FETCH, 1'b0, 32'ha000_0348, 32'h0, 4'h0};
        rows[6]  = '{2, -1, CL_DATA,  1'b0, 32'hc000_0050, 32'h0, 4'h0};
        rows[7]  = '{3, 0,  CL_DATA,  1'b0, 32'h0002_4128, 32'h0, 4'h0};
        rows[8]  = '{3, 1,  CL_FETCH, 1'b0, 32'h0002_5130, 32'h0, 4'h0};
        rows[9]  = '{3, -1, CL_DATA,  1'b0, 32'h0006_0040, 32'h0, 4'h0};
        rows[10] = '{3, -1, CL_DATA,  1'b0, 32'h0006_1040, 32'h0, 4'h0};
        rows[11] = '{4, -1, CL_FETCH, 1'b0, 32'h0002_4128, 32'h0, 4'h0};
        rows[12] = '{4, -1, CL_DATA,  1'b0, 32'h0006_0044, 32'h0, 4'h0};
        rows[13] = '{3, -1, CL_DATA,  1'b0, 32'h0008_0000, 32'h0, 4'h0};
        rows[14] = '{3, -1, CL_DATA,  1'b1, 32'h0002_4128, 32'hdead_beef, 4'b1100};
        rows[15] = '{3, -1, CL_DATA,  1'b0, 32'h0002_4128, 32'h0, 4'h0};
        rows[16] = '{0, -1, CL_BOTH,  1'b1, 32'h0000_0040, 32'hcafe_f00d, 4'b1111};
        rows[17] = '{3, -1, CL_BOTH,  1'b0, 32'h0002_5130, 32'h0, 4'h0};
        rows[18] = '{1, -1, CL_BOTH,  1'b1, 32'h8000_0060, 32'h0bad_c0de, 4'b0011};
    endtask

    task automatic run_row(input int r);
        row_t       row;
        cfg_t       c;
        tlb_entry_t ent;
        vaddr_t     f_va;
        paddr_t     d_pa, f_pa;
        logic       d_flt, f_flt, use_d, use_f;
        logic       d_end, f_end, d_got_flt, f_got_flt;
        word_t      d_rd, f_rd;
        int         cycles, d_cyc, f_cyc, xfer_start, req_start, n_exp;
        row   = rows[r];
        c     = cfgs[row.cfg_sel];
        use_d = (row.client != CL_FETCH);
        use_f = (row.client != CL_DATA);
        // with both clients active the fetch reads the next word
        f_va  = (row.client == CL_BOTH) ? row.vaddr + 32'h4 : row.vaddr;
        @(posedge clk);
        direct_addr <= c.direct;
        dmw0_en     <= c.dmw0_en;
        dmw0_vseg   <= c.dmw0_vseg;
        dmw0_pseg   <= c.dmw0_pseg;
        dmw1_en     <= c.dmw1_en;
        dmw1_vseg   <= c.dmw1_vseg;
        dmw1_pseg   <= c.dmw1_pseg;
        asid        <= c.asid;
        if (row.tlb_sel >= 0) begin
            ent     = tlb_writes[row.tlb_sel];
            tlb_we  <= 1'b1;
            w_index <= tlb_write_idx[row.tlb_sel];
            w_e     <= ent.e;
            w_vppn  <= ent.vppn;
            w_asid  <= ent.asid;
            w_g     <= ent.g;
            w_ppn0  <= ent.ppn0;
            w_v0    <= ent.v0;
            w_ppn1  <= ent.ppn1;
            w_v1    <= ent.v1;
            tlb_model[tlb_write_idx[row.tlb_sel]] = ent;
        end
        ref_translate(c, row.vaddr, d_pa, d_flt);
        ref_translate(c, f_va, f_pa, f_flt);
        @(posedge clk);
        tlb_we     <= 1'b0;
        xfer_start = xfer_count;
        req_start  = req_cycles;
        if (use_f) begin
            fetch_valid <= 1'b1;
            fetch_vaddr <= f_va;
        end
        if (use_d) begin
            data_valid <= 1'b1;
            data_wr    <= row.wr;
            data_vaddr <= row.vaddr;
            data_wdata <= row.wdata;
            data_wstrb <= row.wstrb;
        end
        @(posedge clk);
        fetch_valid <= 1'b0;
        data_valid  <= 1'b0;
        cycles    = 0;
        d_cyc     = 0;
        f_cyc     = 0;
        d_end     = !use_d;
        f_end     = !use_f;
        d_got_flt = 1'b0;
        f_got_flt = 1'b0;
        d_rd      = '0;
        f_rd      = '0;
        while (!(d_end && f_end) && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            // busy rises the cycle after valid
            if (cycles == 1) begin
                if (use_d) check_flag("data_busy after valid", data_busy, 1'b1);
                if (use_f) check_flag("fetch_busy after valid", fetch_busy, 1'b1);
            end
            if (!d_end && (data_done || data_fault)) begin
                d_end     = 1'b1;
                d_got_flt = data_fault;
                d_rd      = data_rdata;
                d_cyc     = cycles;
            end
            if (!f_end && (fetch_done || fetch_fault)) begin
                f_end     = 1'b1;
                f_got_flt = fetch_fault;
                f_rd      = fetch_rdata;
                f_cyc     = cycles;
            end
        end
        if (!(d_end && f_end)) begin
            failures++;
            $display("row %0d: no done or fault from the DUT within %0d cycles", r, TIMEOUT);
            return;
        end
        cycles = 0;
        while ((fetch_busy || data_busy) && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (fetch_busy || data_busy) begin
            failures++;
            $display("row %0d: busy stayed high after the access ended", r);
        end
        n_exp = 0;
        if (use_d) begin
            check_flag("data fault", d_got_flt, d_flt);
            if (d_flt) check_flag("data fault one cycle after valid", d_cyc == 1, 1'b1);
            if (!d_flt) n_exp++;
        end
        if (use_f) begin
            check_flag("fetch fault", f_got_flt, f_flt);
            if (f_flt) check_flag("fetch fault one cycle after valid", f_cyc == 1, 1'b1);
            if (!f_flt) n_exp++;
        end
        check_flag("transfer count", (xfer_count - xfer_start) == n_exp, 1'b1);
        if (n_exp == 0) check_flag("sram_req during fault", req_cycles != req_start, 1'b0);
        // data port has priority and goes first
        if (n_exp > 0) begin
            check_paddr("first bus address", xfer_log[xfer_start[5:0]],
                        (use_d && !d_flt) ? d_pa : f_pa);
        end
        if (n_exp == 2) check_paddr("second bus address", xfer_log[xfer_start[5:0] + 6'd1], f_pa);
        if (use_d && !d_flt && !d_got_flt) begin
            if (row.wr) begin
                shadow[d_pa[9:2]] = merge_bytes(shadow[d_pa[9:2]], row.wdata, row.wstrb);
            end else begin
                check_word("data rdata", d_rd, shadow[d_pa[9:2]]);
            end
        end
        if (use_f && !f_flt && !f_got_flt) check_word("fetch rdata", f_rd, shadow[f_pa[9:2]]);
    endtask

    // sram model with random addr_ok and data_ok delays of 0 to 3 cycles
    initial begin : sram_model
        logic [31:0] rng;
        logic [1:0]  addr_wait;
        logic [1:0]  data_wait;
        logic        busy_mem;
        logic [7:0]  idx;
        word_t       read_word;
        rng       = 32'hae89;
        addr_wait = 2'd0;
        data_wait = 2'd0;
        busy_mem  = 1'b0;
        read_word = '0;
        for (int i = 0; i < 256; i++) mem[i] = fill_word(i);
        sram_addr_ok <= 1'b0;
        sram_data_ok <= 1'b0;
        sram_rdata   <= '0;
        xfer_count   <= 0;
        req_cycles   <= 0;
        forever begin
            @(posedge clk);
            sram_data_ok <= 1'b0;
            if (rst) begin
                sram_addr_ok <= 1'b0;
                busy_mem  = 1'b0;
                addr_wait = 2'd0;
            end else if (busy_mem) begin
                if (sram_req) begin
                    failures++;
                    $display("at %0t: sram_req raised while a transaction is outstanding", $time);
                end
                if (data_wait == 2'd0) begin
                    sram_data_ok <= 1'b1;
                    sram_rdata   <= read_word;
                    busy_mem = 1'b0;
                end else begin
                    data_wait = data_wait - 2'd1;
                end
            end else begin
                if (sram_req) req_cycles <= req_cycles + 1;
                if (sram_req && sram_addr_ok) begin
                    idx = sram_addr[9:2];
                    if (sram_wr) mem[idx] = merge_bytes(mem[idx], sram_wdata, sram_wstrb);
                    read_word = mem[idx];
                    xfer_log[xfer_count[5:0]] <= sram_addr;
                    xfer_count   <= xfer_count + 1;
                    sram_addr_ok <= 1'b0;
                    busy_mem  = 1'b1;
                    rng       = xorshift32(rng);
                    data_wait = rng[1:0];
                    rng       = xorshift32(rng);
                    addr_wait = rng[1:0];
                end else if (addr_wait == 2'd0) begin
                    sram_addr_ok <= 1'b1;
                end else begin
                    addr_wait = addr_wait - 2'd1;
                end
            end
        end
    end

    initial begin : stimulus
        mismatches = 0;
        failures   = 0;
        rst         <= 1'b1;
        direct_addr <= 1'b1;
        dmw0_en     <= 1'b0;
        dmw0_vseg   <= '0;
        dmw0_pseg   <= '0;
        dmw1_en     <= 1'b0;
        dmw1_vseg   <= '0;
        dmw1_pseg   <= '0;
        asid        <= '0;
        tlb_we      <= 1'b0;
        w_index     <= '0;
        w_e         <= 1'b0;
        w_vppn      <= '0;
        w_asid      <= '0;
        w_g         <= 1'b0;
        w_ppn0      <= '0;
        w_v0        <= 1'b0;
        w_ppn1      <= '0;
        w_v1        <= 1'b0;
        fetch_valid <= 1'b0;
        fetch_vaddr <= '0;
        data_valid  <= 1'b0;
        data_wr     <= 1'b0;
        data_wstrb  <= '0;
        data_vaddr  <= '0;
        data_wdata  <= '0;
        for (int i = 0; i < TLB_NUM; i++) tlb_model[i] = '0;
        for (int i = 0; i < 256; i++) shadow[i] = fill_word(i);
        load_table();
        repeat (5) @(posedge clk);
        check_flag("sram_req after reset", sram_req, 1'b0);
        check_flag("fetch_busy after reset", fetch_busy, 1'b0);
        check_flag("data_busy after reset", data_busy, 1'b0);
        check_flag("fetch_done after reset", fetch_done, 1'b0);
        check_flag("data_done after reset", data_done, 1'b0);
        check_flag("fetch_fault after reset", fetch_fault, 1'b0);
        check_flag("data_fault after reset", data_fault, 1'b0);
        rst <= 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) run_row(i);
        repeat (2) @(posedge clk);
        $display("mismatches: %0d, other errors: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- compile.f
common/mmu_pkg.sv
tlb/tlb.sv
design/access_port.sv
design/bus_arbiter.sv
design/core_mem_top.sv
sim/tb_core_mem.sv

//--- Makefile
TOP = tb_core_mem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f compile.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only --timing -f compile.f --top-module core_mem_top
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
